/* cam_pkg.sv */
package cam_pkg;

    ////////////////////
    // frame geometry

    // raw frame size as it arrives from the sensor side
    localparam int RAW_WIDTH  = 8;
    localparam int RAW_HEIGHT = 4;

    // window that is forwarded to the host
    localparam int ROI_WIDTH  = 4;
    localparam int ROI_HEIGHT = 2;

    // corner used until the host moves it
    localparam int DEFAULT_ROI_COL = 2;
    localparam int DEFAULT_ROI_ROW = 1;

    ////////////////////
    // pixel types

    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] coord_t;

    // raw stream beat, sof marks pixel (0,0)
    typedef struct packed {
        logic   sof;
        pixel_t pixel;
    } pixel_beat_t;

    // cropped stream beat
    typedef struct packed {
        logic   first;
        logic   last;
        pixel_t pixel;
    } crop_beat_t;

endpackage

/* host_pkg.sv */
package host_pkg;

    ////////////////////
    // host link types

    typedef logic [7:0]  host_byte_t;
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // one assembled host command
    typedef struct packed {
        logic      is_read;
        reg_addr_t addr;
        reg_data_t data;
    } host_cmd_t;

    // one byte toward the host, last closes a packet
    typedef struct packed {
        logic       last;
        host_byte_t data;
    } tx_beat_t;

    localparam int CMD_BYTES     = 6;
    localparam int REPLY_BYTES   = 4;
    localparam int HEADER_BYTES  = 8;
    localparam int READ_FLAG_BIT = 15;

    // "BIVFRAME"
    localparam logic [63:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;

    ////////////////////
    // register map
    localparam reg_addr_t ADDR_ROI_COL     = 16'h0001;
    localparam reg_addr_t ADDR_ROI_ROW     = 16'h0002;
    localparam reg_addr_t ADDR_FRAME_COUNT = 16'h0003;
    localparam reg_addr_t ADDR_SCRATCH     = 16'h0004;

endpackage

/* cmd_assembler.sv */
`timescale 1ns/1ns

module cmd_assembler
    import host_pkg::*;
(
    input  logic       core_clk,
    input  logic       sys_reset,
    input  host_byte_t rx_byte_i,
    input  logic       rx_valid_i,
    output host_cmd_t  cmd_o,
    output logic       cmd_valid_o
);

    // address bytes first, msb first
    logic [CMD_BYTES*$bits(host_byte_t)-1:0] shift_q;
    logic [2:0]                              count_q;
    logic                                    cmd_valid_q;

    always_ff @(posedge core_clk) begin
        if (rx_valid_i) begin
            shift_q <= {shift_q[(CMD_BYTES-1)*$bits(host_byte_t)-1:0], rx_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            count_q     <= '0;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            if (rx_valid_i) begin
                if (count_q == 3'(CMD_BYTES - 1)) begin
                    count_q     <= '0;
                    cmd_valid_q <= 1'b1;
                end else begin
                    count_q <= count_q + 3'd1;
                end
            end
        end
    end

    // split the word, read flag is dropped from the address
    always_comb begin
        cmd_o.addr                = shift_q[$bits(reg_data_t) +: $bits(reg_addr_t)];
        cmd_o.is_read             = cmd_o.addr[READ_FLAG_BIT];
        cmd_o.addr[READ_FLAG_BIT] = 1'b0;
        cmd_o.data                = shift_q[$bits(reg_data_t)-1:0];
    end

    assign cmd_valid_o = cmd_valid_q;

endmodule

/* const_regs.sv */
`timescale 1ns/1ns

module const_regs
    import cam_pkg::*;
    import host_pkg::*;
(
    input  logic      core_clk,
    input  logic      sys_reset,
    input  host_cmd_t cmd_i,
    input  logic      cmd_valid_i,
    input  logic      frame_sent_i,
    output coord_t    roi_col_o,
    output coord_t    roi_row_o,
    output tx_beat_t  reply_o,
    output logic      reply_valid_o,
    input  logic      reply_ready_i
);

    typedef enum logic [0:0] {
        REPLY_IDLE,
        REPLY_SEND
    } reply_state_t;

    coord_t       roi_col_q;
    coord_t       roi_row_q;
    reg_data_t    scratch_q;
    reg_data_t    frame_count_q;
    reg_data_t    read_data;
    reg_data_t    reply_word_q;
    logic [1:0]   reply_idx_q;
    reply_state_t reply_state_q;

    ////////////////////
    // register file

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            roi_col_q     <= coord_t'(DEFAULT_ROI_COL);
            roi_row_q     <= coord_t'(DEFAULT_ROI_ROW);
            scratch_q     <= '0;
            frame_count_q <= '0;
        end else begin
            if (frame_sent_i) begin
                frame_count_q <= frame_count_q + 32'd1;
            end
            // frame counter is read only, writes to it fall through
            if (cmd_valid_i && !cmd_i.is_read) begin
                case (cmd_i.addr)
                    ADDR_ROI_COL: roi_col_q <= coord_t'(cmd_i.data);
                    ADDR_ROI_ROW: roi_row_q <= coord_t'(cmd_i.data);
                    ADDR_SCRATCH: scratch_q <= cmd_i.data;
                    default: ;
                endcase
            end
        end
    end

    // read decode, unknown address reads as zero
    always_comb begin
        case (cmd_i.addr)
            ADDR_ROI_COL:     read_data = reg_data_t'(roi_col_q);
            ADDR_ROI_ROW:     read_data = reg_data_t'(roi_row_q);
            ADDR_FRAME_COUNT: read_data = frame_count_q;
            ADDR_SCRATCH:     read_data = scratch_q;
            default:          read_data = '0;
        endcase
    end

    ////////////////////
    // reply serializer

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            reply_state_q <= REPLY_IDLE;
            reply_idx_q   <= '0;
        end else begin
            case (reply_state_q)
                REPLY_IDLE: begin
                    // reads while busy are dropped
                    if (cmd_valid_i && cmd_i.is_read) begin
                        reply_state_q <= REPLY_SEND;
                        reply_idx_q   <= '0;
                    end
                end
                REPLY_SEND: begin
                    if (reply_ready_i) begin
                        if (reply_o.last) begin
                            reply_state_q <= REPLY_IDLE;
                        end
                        reply_idx_q <= reply_idx_q + 2'd1;
                    end
                end
                default: reply_state_q <= REPLY_IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (reply_state_q == REPLY_IDLE && cmd_valid_i && cmd_i.is_read) begin
            reply_word_q <= read_data;
        end else if (reply_state_q == REPLY_SEND && reply_ready_i) begin
            reply_word_q <= {reply_word_q[23:0], 8'h00};
        end
    end

    assign reply_valid_o = (reply_state_q == REPLY_SEND);
    assign reply_o.data  = reply_word_q[31:24];
    assign reply_o.last  = (reply_idx_q == 2'(REPLY_BYTES - 1));

    assign roi_col_o = roi_col_q;
    assign roi_row_o = roi_row_q;

endmodule

/* roi_cropper.sv */
`timescale 1ns/1ns

module roi_cropper
    import cam_pkg::*;
(
    input  logic        core_clk,
    input  logic        sys_reset,
    input  pixel_beat_t pix_i,
    input  logic        pix_valid_i,
    output logic        pix_ready_o,
    input  coord_t      roi_col_i,
    input  coord_t      roi_row_i,
    output crop_beat_t  crop_o,
    output logic        crop_valid_o,
    input  logic        crop_ready_i
);

    // position of the next expected pixel
    coord_t     col_q;
    coord_t     row_q;
    // corner in use for the current frame
    coord_t     corner_col_q;
    coord_t     corner_row_q;
    coord_t     cur_col;
    coord_t     cur_row;
    coord_t     win_col;
    coord_t     win_row;
    logic       in_window;
    logic       accept;
    crop_beat_t crop_q;
    logic       crop_valid_q;

    assign pix_ready_o = !crop_valid_q || crop_ready_i;
    assign accept      = pix_valid_i && pix_ready_o;

    always_comb begin
        cur_col = pix_i.sof ? '0 : col_q;
        cur_row = pix_i.sof ? '0 : row_q;
        // new corner takes effect at the sof pixel itself
        win_col = pix_i.sof ? roi_col_i : corner_col_q;
        win_row = pix_i.sof ? roi_row_i : corner_row_q;
        in_window = (cur_col >= win_col) && (cur_col < win_col + coord_t'(ROI_WIDTH))
                 && (cur_row >= win_row) && (cur_row < win_row + coord_t'(ROI_HEIGHT));
    end

    ////////////////////
    // raster tracking

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q        <= '0;
            row_q        <= '0;
            corner_col_q <= coord_t'(DEFAULT_ROI_COL);
            corner_row_q <= coord_t'(DEFAULT_ROI_ROW);
        end else if (accept) begin
            corner_col_q <= win_col;
            corner_row_q <= win_row;
            if (cur_col == coord_t'(RAW_WIDTH - 1)) begin
                col_q <= '0;
                row_q <= (cur_row == coord_t'(RAW_HEIGHT - 1)) ? '0 : cur_row + 16'd1;
            end else begin
                col_q <= cur_col + 16'd1;
                row_q <= cur_row;
            end
        end
    end

    ////////////////////
    // output register

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            crop_valid_q <= 1'b0;
        end else if (accept && in_window) begin
            crop_valid_q <= 1'b1;
        end else if (crop_ready_i) begin
            crop_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept && in_window) begin
            crop_q.pixel <= pix_i.pixel;
            crop_q.first <= (cur_col == win_col) && (cur_row == win_row);
            crop_q.last  <= (cur_col == win_col + coord_t'(ROI_WIDTH - 1))
                         && (cur_row == win_row + coord_t'(ROI_HEIGHT - 1));
        end
    end

    assign crop_o       = crop_q;
    assign crop_valid_o = crop_valid_q;

endmodule

/* frame_framer.sv */
`timescale 1ns/1ns

module frame_framer
    import cam_pkg::*;
    import host_pkg::*;
(
    input  logic       core_clk,
    input  logic       sys_reset,
    input  crop_beat_t crop_i,
    input  logic       crop_valid_i,
    output logic       crop_ready_o,
    output tx_beat_t   frame_o,
    output logic       frame_valid_o,
    input  logic       frame_ready_i,
    output logic       frame_sent_o
);

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_HEADER,
        FRAME_PIXELS
    } frame_state_t;

    frame_state_t state_q;
    logic [2:0]   hdr_idx_q;
    logic         frame_sent_q;
    logic         pix_done;

    // last pixel of the frame leaves on this cycle
    assign pix_done = (state_q == FRAME_PIXELS) && crop_valid_i && frame_ready_i
                   && crop_i.last;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q      <= FRAME_IDLE;
            hdr_idx_q    <= '0;
            frame_sent_q <= 1'b0;
        end else begin
            frame_sent_q <= pix_done;
            case (state_q)
                FRAME_IDLE: begin
                    // first beat stays parked at the cropper output
                    if (crop_valid_i && crop_i.first) begin
                        state_q   <= FRAME_HEADER;
                        hdr_idx_q <= '0;
                    end
                end
                FRAME_HEADER: begin
                    if (frame_ready_i) begin
                        if (hdr_idx_q == 3'(HEADER_BYTES - 1)) begin
                            state_q <= FRAME_PIXELS;
                        end
                        hdr_idx_q <= hdr_idx_q + 3'd1;
                    end
                end
                FRAME_PIXELS: begin
                    if (pix_done) begin
                        state_q <= FRAME_IDLE;
                    end
                end
                default: state_q <= FRAME_IDLE;
            endcase
        end
    end

    always_comb begin
        frame_o.last  = 1'b0;
        frame_o.data  = MAGIC_NUM[(HEADER_BYTES - 1 - int'(hdr_idx_q))*8 +: 8];
        frame_valid_o = 1'b0;
        crop_ready_o  = 1'b0;
        case (state_q)
            // stray beats without a frame start are discarded
            FRAME_IDLE:   crop_ready_o = crop_valid_i && !crop_i.first;
            FRAME_HEADER: frame_valid_o = 1'b1;
            FRAME_PIXELS: begin
                frame_o.data  = crop_i.pixel;
                frame_o.last  = crop_i.last;
                frame_valid_o = crop_valid_i;
                crop_ready_o  = frame_ready_i;
            end
            default: ;
        endcase
    end

    assign frame_sent_o = frame_sent_q;

endmodule

/* tx_arbiter.sv */
`timescale 1ns/1ns

module tx_arbiter
    import host_pkg::*;
(
    input  logic     core_clk,
    input  logic     sys_reset,
    input  tx_beat_t reply_i,
    input  logic     reply_valid_i,
    output logic     reply_ready_o,
    input  tx_beat_t frame_i,
    input  logic     frame_valid_i,
    output logic     frame_ready_o,
    output tx_beat_t tx_o,
    output logic     tx_valid_o,
    input  logic     tx_ready_i
);

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_REPLY,
        GRANT_FRAME
    } grant_t;

    grant_t grant_q;
    logic   sel_reply;
    logic   sel_frame;
    logic   pkt_end;

    // replies win when nothing is locked
    assign sel_reply = (grant_q == GRANT_REPLY) || (grant_q == GRANT_NONE && reply_valid_i);
    assign sel_frame = (grant_q == GRANT_FRAME)
                    || (grant_q == GRANT_NONE && !reply_valid_i && frame_valid_i);

    assign tx_o          = sel_reply ? reply_i : frame_i;
    assign tx_valid_o    = sel_reply ? reply_valid_i : (sel_frame && frame_valid_i);
    assign reply_ready_o = sel_reply && tx_ready_i;
    assign frame_ready_o = sel_frame && tx_ready_i;
    assign pkt_end       = tx_valid_o && tx_ready_i && tx_o.last;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            grant_q <= GRANT_NONE;
        end else if (grant_q == GRANT_NONE) begin
            // lock once a beat is offered so the port data stays stable
            if (tx_valid_o && !pkt_end) begin
                grant_q <= sel_reply ? GRANT_REPLY : GRANT_FRAME;
            end
        end else if (pkt_end) begin
            grant_q <= GRANT_NONE;
        end
    end

endmodule

/* previewer_top.sv */
`timescale 1ns/1ns

module previewer_top
    import cam_pkg::*;
    import host_pkg::*;
(
    input  logic        core_clk,
    input  logic        sys_reset,
    input  host_byte_t  rx_byte_i,
    input  logic        rx_valid_i,
    input  pixel_beat_t pix_i,
    input  logic        pix_valid_i,
    output logic        pix_ready_o,
    output tx_beat_t    tx_o,
    output logic        tx_valid_o,
    input  logic        tx_ready_i
);

    ////////////////////
    // host command side
    host_cmd_t cmd;
    logic      cmd_valid;
    coord_t    roi_col;
    coord_t    roi_row;
    tx_beat_t  reply;
    logic      reply_valid;
    logic      reply_ready;
    logic      frame_sent;

    ////////////////////
    // pixel side
    crop_beat_t crop;
    logic       crop_valid;
    logic       crop_ready;
    tx_beat_t   frame;
    logic       frame_valid;
    logic       frame_ready;

    cmd_assembler u_cmd_assembler (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .cmd_o      (cmd),
        .cmd_valid_o(cmd_valid)
    );

    const_regs u_const_regs (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .cmd_i        (cmd),
        .cmd_valid_i  (cmd_valid),
        .frame_sent_i (frame_sent),
        .roi_col_o    (roi_col),
        .roi_row_o    (roi_row),
        .reply_o      (reply),
        .reply_valid_o(reply_valid),
        .reply_ready_i(reply_ready)
    );

    roi_cropper u_roi_cropper (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .pix_ready_o (pix_ready_o),
        .roi_col_i   (roi_col),
        .roi_row_i   (roi_row),
        .crop_o      (crop),
        .crop_valid_o(crop_valid),
        .crop_ready_i(crop_ready)
    );

    frame_framer u_frame_framer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .crop_i       (crop),
        .crop_valid_i (crop_valid),
        .crop_ready_o (crop_ready),
        .frame_o      (frame),
        .frame_valid_o(frame_valid),
        .frame_ready_i(frame_ready),
        .frame_sent_o (frame_sent)
    );

    // one host port, replies and frames take turns per packet
    tx_arbiter u_tx_arbiter (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .reply_i      (reply),
        .reply_valid_i(reply_valid),
        .reply_ready_o(reply_ready),
        .frame_i      (frame),
        .frame_valid_i(frame_valid),
        .frame_ready_o(frame_ready),
        .tx_o         (tx_o),
        .tx_valid_o   (tx_valid_o),
        .tx_ready_i   (tx_ready_i)
    );

endmodule

/* tb_previewer.sv */
`timescale 1ns/1ns

module tb_previewer
    import cam_pkg::*;
    import host_pkg::*;
();

    typedef enum {
        OP_WRITE,
        OP_READ,
        OP_FRAME,
        OP_FRAME_READ
    } op_t;

    localparam int        FRAME_PIXELS = RAW_WIDTH * RAW_HEIGHT;
    localparam int        ROI_PIXELS   = ROI_WIDTH * ROI_HEIGHT;
    localparam reg_addr_t READ_FLAG    = 16'h8000;

    logic        core_clk;
    logic        sys_reset;
    host_byte_t  rx_byte_i;
    logic        rx_valid_i;
    pixel_beat_t pix_i;
    logic        pix_valid_i;
    logic        pix_ready_o;
    tx_beat_t    tx_o;
    logic        tx_valid_o;
    logic        tx_ready_i;

    // stimulus table with one entry per row
    string       row_name[$];
    op_t         row_op[$];
    reg_addr_t   row_addr[$];
    reg_data_t   row_data[$];

    logic [31:0] lfsr_q;
    string       cur_name;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    // corner as the host sees it
    coord_t      mdl_col;
    coord_t      mdl_row;
    host_byte_t  host_data_q[$];
    logic        host_last_q[$];
    host_byte_t  exp_bytes_q[$];

    previewer_top UUT (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .pix_i      (pix_i),
        .pix_valid_i(pix_valid_i),
        .pix_ready_o(pix_ready_o),
        .tx_o       (tx_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i)
    );

    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    ////////////////////
    // helpers

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h",
                     cur_name, what, exp_val, act_val);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic pixel_t random_byte();
        pixel_t value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], next_bit()};
        end
        return value;
    endfunction

    // every cycle also picks a random stall on the host port
    task automatic tick();
        @(posedge core_clk);
        tx_ready_i <= next_bit();
    endtask

    task automatic add_row(input string name, input op_t op, input reg_addr_t addr,
                           input reg_data_t data);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
    endtask

    function automatic int row_bytes(input op_t op);
        case (op)
            OP_WRITE: return CMD_BYTES;
            OP_READ:  return CMD_BYTES + REPLY_BYTES;
            OP_FRAME: return FRAME_PIXELS + HEADER_BYTES + ROI_PIXELS;
            default:  return FRAME_PIXELS + HEADER_BYTES + ROI_PIXELS + CMD_BYTES + REPLY_BYTES;
        endcase
    endfunction

    task automatic send_cmd(input reg_addr_t addr, input reg_data_t data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = 0; i < CMD_BYTES; i++) begin
            tick();
            rx_valid_i <= 1'b1;
            rx_byte_i  <= word[47-8*i -: 8];
        end
        tick();
        rx_valid_i <= 1'b0;
    endtask

    task automatic queue_reply(input reg_data_t data);
        for (int i = 0; i < REPLY_BYTES; i++) begin
            exp_bytes_q.push_back(data[31-8*i -: 8]);
        end
    endtask

    // compares the next packet on the host port with last only on its final byte
    task automatic check_packet();
        int n;
        n = exp_bytes_q.size();
        while (host_data_q.size() < n) begin
            tick();
        end
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("byte %0d", i), exp_bytes_q[i], host_data_q.pop_front());
            check_value($sformatf("last flag of byte %0d", i), i == n - 1,
                        host_last_q.pop_front());
        end
        exp_bytes_q.delete();
    endtask

    task automatic run_frame(input logic with_read, input reg_addr_t rd_addr,
                             input reg_data_t rd_exp);
        pixel_t      pixels[FRAME_PIXELS];
        logic [47:0] word;
        string       magic;
        int          sent;
        int          cmd_idx;
        int          read_at;
        logic        accepted;
        magic   = "BIVFRAME";
        word    = {rd_addr | READ_FLAG, 32'h0};
        sent    = 0;
        cmd_idx = with_read ? 0 : CMD_BYTES;
        // past the first window pixel, so the header already owns the port
        read_at = int'(mdl_row) * RAW_WIDTH + int'(mdl_col) + 2;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            pixels[i] = random_byte();
        end
        for (int i = 0; i < HEADER_BYTES; i++) begin
            exp_bytes_q.push_back(magic[i]);
        end
        // reference crop in raster order
        for (int r = 0; r < ROI_HEIGHT; r++) begin
            for (int c = 0; c < ROI_WIDTH; c++) begin
                exp_bytes_q.push_back(
                    pixels[(int'(mdl_row) + r) * RAW_WIDTH + int'(mdl_col) + c]);
            end
        end
        while (sent < FRAME_PIXELS || cmd_idx < CMD_BYTES) begin
            tick();
            accepted = pix_valid_i && pix_ready_o;
            if (accepted) begin
                sent++;
            end
            // a pending pixel is held until it is taken
            if (!pix_valid_i || accepted) begin
                if (sent < FRAME_PIXELS && next_bit()) begin
                    pix_valid_i <= 1'b1;
                    pix_i.sof   <= (sent == 0);
                    pix_i.pixel <= pixels[sent];
                end else begin
                    pix_valid_i <= 1'b0;
                end
            end
            if (cmd_idx < CMD_BYTES && sent >= read_at) begin
                rx_valid_i <= 1'b1;
                rx_byte_i  <= word[47-8*cmd_idx -: 8];
                cmd_idx++;
            end else begin
                rx_valid_i <= 1'b0;
            end
        end
        tick();
        rx_valid_i  <= 1'b0;
        pix_valid_i <= 1'b0;
        check_packet();
        if (with_read) begin
            queue_reply(rd_exp);
            check_packet();
        end
    endtask

    task automatic build_table();
        add_row("rd_col_reset",     OP_READ,       ADDR_ROI_COL,     32'd2);
        add_row("rd_row_reset",     OP_READ,       ADDR_ROI_ROW,     32'd1);
        add_row("rd_scratch_reset", OP_READ,       ADDR_SCRATCH,     32'd0);
        add_row("frame_default",    OP_FRAME,      16'h0000,         32'd0);
        add_row("rd_count_one",     OP_READ,       ADDR_FRAME_COUNT, 32'd1);
        add_row("frame_with_read",  OP_FRAME_READ, ADDR_SCRATCH,     32'd0);
        add_row("wr_col",           OP_WRITE,      ADDR_ROI_COL,     32'd4);
        add_row("wr_row",           OP_WRITE,      ADDR_ROI_ROW,     32'd2);
        add_row("wr_scratch",       OP_WRITE,      ADDR_SCRATCH,     32'hA5C3_0F96);
        add_row("wr_count",         OP_WRITE,      ADDR_FRAME_COUNT, 32'h0000_0055);
        add_row("rd_scratch",       OP_READ,       ADDR_SCRATCH,     32'hA5C3_0F96);
        add_row("rd_count_kept",    OP_READ,       ADDR_FRAME_COUNT, 32'd2);
        add_row("rd_col_new",       OP_READ,       ADDR_ROI_COL,     32'd4);
        add_row("frame_new_corner", OP_FRAME,      16'h0000,         32'd0);
        add_row("frame_again",      OP_FRAME,      16'h0000,         32'd0);
        add_row("rd_count_final",   OP_READ,       ADDR_FRAME_COUNT, 32'd4);
        add_row("rd_unknown",       OP_READ,       16'h0007,         32'd0);
    endtask

    ////////////////////
    // host port collector and watchdog

    // records the beat that the next rising edge transfers
    always @(negedge core_clk) begin
        if (!sys_reset && tx_valid_o && tx_ready_i) begin
            host_data_q.push_back(tx_o.data);
            host_last_q.push_back(tx_o.last);
        end
    end

    always @(posedge core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            abort_run();
        end
    end

    ////////////////////
    // main sequence

    initial begin
        sys_reset   = 1'b1;
        rx_byte_i   = '0;
        rx_valid_i  = 1'b0;
        pix_i       = '0;
        pix_valid_i = 1'b0;
        tx_ready_i  = 1'b0;
        lfsr_q      = 32'h6194_8867;
        mdl_col     = coord_t'(DEFAULT_ROI_COL);
        mdl_row     = coord_t'(DEFAULT_ROI_ROW);
        cur_name    = "reset";
        build_table();
        cycle_limit = 200;
        foreach (row_op[r]) begin
            cycle_limit += row_bytes(row_op[r]) * 4;
        end

        repeat (16) tick();
        sys_reset <= 1'b0;
        tick();
        check_value("tx_valid_o after reset", 1'b0, tx_valid_o);
        check_value("pix_ready_o after reset", 1'b1, pix_ready_o);

        for (int r = 0; r < row_op.size(); r++) begin
            cur_name = row_name[r];
            case (row_op[r])
                OP_WRITE: begin
                    send_cmd(row_addr[r], row_data[r]);
                    if (row_addr[r] == ADDR_ROI_COL) begin
                        mdl_col = coord_t'(row_data[r]);
                    end
                    if (row_addr[r] == ADDR_ROI_ROW) begin
                        mdl_row = coord_t'(row_data[r]);
                    end
                end
                OP_READ: begin
                    send_cmd(row_addr[r] | READ_FLAG, 32'h0);
                    queue_reply(row_data[r]);
                    check_packet();
                end
                OP_FRAME:      run_frame(1'b0, row_addr[r], row_data[r]);
                OP_FRAME_READ: run_frame(1'b1, row_addr[r], row_data[r]);
                default: ;
            endcase
        end

        cur_name = "drain";
        repeat (20) tick();
        assert (host_data_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("the host port sent %0d bytes that no operation asked for",
                     host_data_q.size());
            abort_run();
        end
    end

endmodule

/* files.f */
cam_pkg.sv
host_pkg.sv
cmd_assembler.sv
const_regs.sv
roi_cropper.sv
frame_framer.sv
tx_arbiter.sv
previewer_top.sv
tb_previewer.sv
